//--- rtl/exec_unit.sv
/*
 * Execute stage: operand select, ALU and accumulator
 * Owns the data stack for PSH, POP and ADS
 */

`timescale 1ns/100ps

module exec_unit (
	input  logic                   clk,
	input  logic                   rst,
	input  stack_cpu_pkg::opcode_t opcode,
	input  stack_cpu_pkg::word_t   mem_data_rd,
	input  stack_cpu_pkg::word_t   io_in,
	output stack_cpu_pkg::word_t   acc,
	output stack_cpu_pkg::word_t   acc_next
);

	import stack_cpu_pkg::*;

	word_t io_in_r;
	word_t ds_top;
	word_t opnd;
	logic  ds_push;
	logic  ds_pop;

	// Port input --------------------
	// Sampled at the end of the INN fetch cycle
	always_ff @(posedge clk) begin
		io_in_r <= io_in;
	end

	// Data stack --------------------
	assign ds_push = (opcode == PSH);
	// ADS consumes the top as well
	assign ds_pop  = (opcode == POP) || (opcode == ADS);

	lifo_stack #(
		.DEPTH     (DSTACK_DEPTH),
		.payload_t (word_t)
	) u_dstack (
		.clk  (clk),
		.rst  (rst),
		.push (ds_push),
		.pop  (ds_pop),
		.din  (acc),
		.top  (ds_top)
	);

	// Operand select
	always_comb begin
		if (opcode == INN) begin
			opnd = io_in_r;
		end else if (ds_pop) begin
			opnd = ds_top;
		end else begin
			// Memory data from the fetch-time read
			opnd = mem_data_rd;
		end
	end

	// ALU --------------------
	always_comb begin
		case (opcode)
			LOD, INN, POP: acc_next = opnd;
			ADD, ADS:      acc_next = acc + opnd;
			AND:           acc_next = acc & opnd;
			XOR:           acc_next = acc ^ opnd;
			// NOP, SET, PSH, OUT keep the accumulator
			default:       acc_next = acc;
		endcase
	end

	// Accumulator
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else begin
			acc <= acc_next;
		end
	end

endmodule

//--- rtl/instr_fetch.sv
/*
 * Fetch stage: PC, control-flow decision and return stack
 * Hands a registered opcode and operand to execute
 * and issues the fetch-time memory and port read requests
 */

`timescale 1ns/100ps

module instr_fetch (
	input  logic                    clk,
	input  logic                    rst,
	input  stack_cpu_pkg::instr_t   instr,
	output stack_cpu_pkg::iaddr_t   instr_addr,
	input  stack_cpu_pkg::word_t    acc_next,
	output stack_cpu_pkg::opcode_t  ex_opcode,
	output stack_cpu_pkg::operand_t ex_operand,
	output stack_cpu_pkg::daddr_t   mem_addr_rd,
	output logic                    req_in,
	output stack_cpu_pkg::io_addr_t addr_in
);

	import stack_cpu_pkg::*;

	// Raw fields of the fetched word
	opcode_t  f_opcode;
	operand_t f_operand;
	logic     is_flow;

	iaddr_t pc;
	iaddr_t pc_inc;
	iaddr_t pc_next;
	iaddr_t rs_top;

	assign f_opcode  = opcode_t'(instr[INSTR_W-1:OPERAND_W]);
	assign f_operand = instr[OPERAND_W-1:0];
	assign is_flow   = f_opcode inside {JMP, JIZ, CAL, RET};
	assign pc_inc    = pc + 1'b1;

	// Return stack --------------------
	// CAL saves the address after itself
	lifo_stack #(
		.DEPTH     (RSTACK_DEPTH),
		.payload_t (iaddr_t)
	) u_rstack (
		.clk  (clk),
		.rst  (rst),
		.push (f_opcode == CAL),
		.pop  (f_opcode == RET),
		.din  (pc_inc),
		.top  (rs_top)
	);

	// Next address, decided on the raw word so no bubble
	always_comb begin
		case (f_opcode)
			JMP, CAL: pc_next = f_operand;
			// acc_next is the result of the instruction ahead of JIZ
			JIZ:      pc_next = (acc_next == '0) ? f_operand : pc_inc;
			RET:      pc_next = rs_top;
			default:  pc_next = pc_inc;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	// Instruction register --------------------
	// Control flow is finished here and executes as NOP
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ex_opcode <= NOP;
		end else begin
			ex_opcode <= is_flow ? NOP : f_opcode;
		end
	end

	always_ff @(posedge clk) begin
		ex_operand <= f_operand;
	end

	// Fetch-time reads, data arrives in execute
	assign instr_addr  = pc;
	assign mem_addr_rd = f_operand;
	assign addr_in     = f_operand[IO_ADDR_W-1:0];
	assign req_in      = (f_opcode == INN);

endmodule

//--- rtl/io_mem_ctrl.sv
/*
 * Output side: data-memory write for SET
 * and the registered port strobe for OUT
 */

`timescale 1ns/100ps

module io_mem_ctrl (
	input  logic                    clk,
	input  logic                    rst,
	input  stack_cpu_pkg::opcode_t  opcode,
	input  stack_cpu_pkg::operand_t operand,
	input  stack_cpu_pkg::word_t    acc,
	output logic                    mem_wr,
	output stack_cpu_pkg::daddr_t   mem_addr_wr,
	output stack_cpu_pkg::word_t    mem_data_wr,
	output logic                    out_en,
	output stack_cpu_pkg::io_addr_t addr_out,
	output stack_cpu_pkg::word_t    io_out
);

	import stack_cpu_pkg::*;

	// Memory write, same cycle as execute
	assign mem_wr      = (opcode == SET);
	assign mem_addr_wr = operand;
	assign mem_data_wr = acc;

	// Port output --------------------
	// One-cycle strobe after the OUT execute cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_en <= 1'b0;
		end else begin
			out_en <= (opcode == OUT);
		end
	end

	// Address and data hold until the next OUT
	always_ff @(posedge clk) begin
		if (opcode == OUT) begin
			addr_out <= operand[IO_ADDR_W-1:0];
			io_out   <= acc;
		end
	end

endmodule

//--- rtl/lifo_stack.sv
/*
 * LIFO stack with a wrapping pointer
 * Serves both return addresses and data words
 */

`timescale 1ns/100ps

module lifo_stack #(
	parameter int  DEPTH     = stack_cpu_pkg::DSTACK_DEPTH,
	parameter type payload_t = stack_cpu_pkg::word_t
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     push,
	input  logic     pop,
	input  payload_t din,
	output payload_t top
);

	localparam int PTR_W = $clog2(DEPTH);

	// Pointer marks the next free slot
	logic [PTR_W-1:0] ptr;
	logic [PTR_W-1:0] below;
	payload_t         mem [DEPTH];

	// Pointer --------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
		end else if (push) begin
			ptr <= ptr + 1'b1;
		end else if (pop) begin
			ptr <= ptr - 1'b1;
		end
	end

	// Storage, no reset
	always_ff @(posedge clk) begin
		if (push) begin
			mem[ptr] <= din;
		end
	end

	// Top of stack is the last written entry
	assign below = ptr - 1'b1;
	assign top   = mem[below];

endmodule

//--- rtl/stack_cpu.sv
/*
 * stack_cpu top level
 * Fetch, execute and output side joined by loose wires
 */

`timescale 1ns/100ps

module stack_cpu (
	input  logic                    clk,
	input  logic                    rst,
	// Instruction memory, combinational read
	input  stack_cpu_pkg::instr_t   instr,
	output stack_cpu_pkg::iaddr_t   instr_addr,
	// Data memory, synchronous read
	output stack_cpu_pkg::daddr_t   mem_addr_rd,
	input  stack_cpu_pkg::word_t    mem_data_rd,
	output logic                    mem_wr,
	output stack_cpu_pkg::daddr_t   mem_addr_wr,
	output stack_cpu_pkg::word_t    mem_data_wr,
	// Port input
	output logic                    req_in,
	output stack_cpu_pkg::io_addr_t addr_in,
	input  stack_cpu_pkg::word_t    io_in,
	// Port output
	output logic                    out_en,
	output stack_cpu_pkg::io_addr_t addr_out,
	output stack_cpu_pkg::word_t    io_out
);

	import stack_cpu_pkg::*;

	opcode_t  ex_opcode;
	operand_t ex_operand;
	word_t    acc;
	word_t    acc_next;

	// Input side --------------------
	instr_fetch u_fetch (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_addr  (instr_addr),
		.acc_next    (acc_next),
		.ex_opcode   (ex_opcode),
		.ex_operand  (ex_operand),
		.mem_addr_rd (mem_addr_rd),
		.req_in      (req_in),
		.addr_in     (addr_in)
	);

	// Processing --------------------
	exec_unit u_exec (
		.clk         (clk),
		.rst         (rst),
		.opcode      (ex_opcode),
		.mem_data_rd (mem_data_rd),
		.io_in       (io_in),
		.acc         (acc),
		.acc_next    (acc_next)
	);

	// Output side --------------------
	io_mem_ctrl u_io_mem (
		.clk         (clk),
		.rst         (rst),
		.opcode      (ex_opcode),
		.operand     (ex_operand),
		.acc         (acc),
		.mem_wr      (mem_wr),
		.mem_addr_wr (mem_addr_wr),
		.mem_data_wr (mem_data_wr),
		.out_en      (out_en),
		.addr_out    (addr_out),
		.io_out      (io_out)
	);

endmodule

//--- rtl/stack_cpu_pkg.sv
/*
 * Shared definitions for the stack_cpu core
 * Field widths, stack depths, opcode encoding and word types
 */

package stack_cpu_pkg;

	// Field widths --------------------
	localparam int WORD_W    = 16;
	localparam int OPCODE_W  = 7;
	localparam int OPERAND_W = 9;
	localparam int INSTR_W   = OPCODE_W + OPERAND_W;

	// Address spaces
	localparam int IADDR_W   = 9;
	localparam int DADDR_W   = 9;
	localparam int IO_ADDR_W = 3;

	// Stack sizes, pointers wrap on overflow
	localparam int RSTACK_DEPTH = 8;
	localparam int DSTACK_DEPTH = 8;

	// Types --------------------
	typedef logic [WORD_W-1:0]    word_t;
	// Opcode in the upper 7 bits, operand below
	typedef logic [INSTR_W-1:0]   instr_t;
	typedef logic [OPERAND_W-1:0] operand_t;
	typedef logic [IADDR_W-1:0]   iaddr_t;
	typedef logic [DADDR_W-1:0]   daddr_t;
	typedef logic [IO_ADDR_W-1:0] io_addr_t;

	// Opcode map
	typedef enum logic [OPCODE_W-1:0] {
		NOP = 7'd0,
		LOD = 7'd1,
		SET = 7'd2,
		PSH = 7'd3,
		POP = 7'd4,
		ADD = 7'd5,
		AND = 7'd6,
		XOR = 7'd7,
		ADS = 7'd8,
		INN = 7'd9,
		OUT = 7'd10,
		// Control flow, resolved in fetch
		JMP = 7'd13,
		JIZ = 7'd14,
		CAL = 7'd15,
		RET = 7'd16
	} opcode_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the stack_cpu testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
	-f stack_cpu.f \
	--top-module tb_stack_cpu \
	-o sim_stack_cpu

./obj_dir/sim_stack_cpu | tee sim.log

# The log decides the result
if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
exit 0

//--- include/tb_ref_model.svh
/*
 * Program images and reference interpreter for the stack_cpu testbench
 * Included inside the testbench module, uses its memories and queues
 */

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Program images --------------------
task automatic emit(input opcode_t op, input int opd);
	imem[iaddr_t'(load_ptr)] = {op, operand_t'(opd)};
	load_ptr++;
endtask

// Final OUT to port 7, then park on a jump to itself
task automatic emit_end();
	emit(OUT, 7);
	emit(JMP, load_ptr);
endtask

task automatic load_program(input int prog);
	for (int i = 0; i < IMEM_SIZE; i++) begin
		imem[i] = '0;
	end
	load_ptr = 0;
	// Every program opens with NOP
	emit(NOP, 0);
	case (prog)
		// Memory-operand ALU chain
		0: begin
			emit(LOD, 1);
			emit(ADD, 2);
			emit(OUT, 0);
			emit(AND, 3);
			emit(OUT, 1);
			emit(XOR, 4);
			emit(OUT, 2);
			emit(ADD, 5);
			emit_end();
		end
		// SET then LOD of the same address at once
		1: begin
			emit(LOD, 6);
			emit(SET, 9'h100);
			emit(LOD, 9'h100);
			emit(ADD, 7);
			emit(SET, 9'h101);
			emit(LOD, 9'h101);
			emit_end();
		end
		// Data stack, LIFO order and sums
		2: begin
			emit(LOD, 10);
			emit(PSH, 0);
			emit(LOD, 11);
			emit(PSH, 0);
			emit(LOD, 12);
			emit(PSH, 0);
			emit(POP, 0);
			emit(OUT, 0);
			emit(ADS, 0);
			emit(OUT, 1);
			emit(ADS, 0);
			emit_end();
		end
		// Count-down loop, 0x1f0 holds minus one, 0x1f1 the count
		3: begin
			emit(LOD, 9'h1f1);
			emit(SET, 9'h1f2);
			// Loop top at 3
			emit(OUT, 0);
			emit(LOD, 9'h1f2);
			emit(ADD, 9'h1f0);
			emit(SET, 9'h1f2);
			emit(JIZ, 9);
			emit(JMP, 3);
			emit_end();
		end
		// Nested calls, main at 1, sub A at 6, sub B at 10
		4: begin
			emit(LOD, 13);
			emit(CAL, 6);
			emit(OUT, 1);
			emit_end();
			emit(OUT, 2);
			emit(CAL, 10);
			emit(OUT, 3);
			emit(RET, 0);
			emit(XOR, 14);
			emit(OUT, 4);
			emit(RET, 0);
		end
		// Port input echoed on the same port
		default: begin
			emit(INN, 1);
			emit(OUT, 1);
			emit(INN, 4);
			emit(OUT, 4);
			emit(INN, 6);
			emit(OUT, 6);
			emit(INN, 2);
			emit(XOR, 20);
			emit_end();
		end
	endcase
endtask

// Reference interpreter --------------------
// Program order, one instruction per step, appends expected events
function automatic int stack_cpu_ref();
	word_t                           mem_c [DMEM_SIZE];
	word_t                           ds [DSTACK_DEPTH];
	iaddr_t                          rs [RSTACK_DEPTH];
	logic [$clog2(DSTACK_DEPTH)-1:0] dp;
	logic [$clog2(RSTACK_DEPTH)-1:0] rp;
	iaddr_t                          pc;
	word_t                           acc;
	opcode_t                         op;
	operand_t                        opd;
	int                              steps;
	logic                            running;

	// Private copy of the memory image
	for (int i = 0; i < DMEM_SIZE; i++) begin
		mem_c[i] = mem_init[i];
	end
	pc      = '0;
	acc     = '0;
	dp      = '0;
	rp      = '0;
	steps   = 0;
	running = 1'b1;

	while (running && steps < REF_STEP_CAP) begin
		op  = opcode_t'(imem[pc][INSTR_W-1:OPERAND_W]);
		opd = imem[pc][OPERAND_W-1:0];
		steps++;
		// Fall-through address, also the return address
		pc = pc + 1'b1;
		case (op)
			LOD: acc = mem_c[opd];
			ADD: acc = acc + mem_c[opd];
			AND: acc = acc & mem_c[opd];
			XOR: acc = acc ^ mem_c[opd];
			INN: acc = io_table[opd[IO_ADDR_W-1:0]];
			SET: begin
				mem_c[opd] = acc;
				exp_wr_addr.push_back(opd);
				exp_wr_data.push_back(acc);
			end
			PSH: begin
				ds[dp] = acc;
				dp     = dp + 1'b1;
			end
			POP: begin
				dp  = dp - 1'b1;
				acc = ds[dp];
			end
			ADS: begin
				dp  = dp - 1'b1;
				acc = acc + ds[dp];
			end
			OUT: begin
				exp_out_addr.push_back(opd[IO_ADDR_W-1:0]);
				exp_out_data.push_back(acc);
				// Port 7 closes the program
				running = (opd[IO_ADDR_W-1:0] != 3'd7);
			end
			JMP: pc = opd;
			JIZ: begin
				if (acc == '0) begin
					pc = opd;
				end
			end
			CAL: begin
				rs[rp] = pc;
				rp     = rp + 1'b1;
				pc     = opd;
			end
			RET: begin
				rp = rp - 1'b1;
				pc = rs[rp];
			end
			default: ;
		endcase
	end
	return steps;
endfunction

`endif

//--- sim/tb_stack_cpu.sv
/*
 * Testbench for the stack_cpu core
 * Memory and port models, program sequencing
 * and in-order checks of writes and port outputs
 */

`timescale 1ns/100ps

module tb_stack_cpu;

	import stack_cpu_pkg::*;

	localparam int NUM_PROGS    = 6;
	localparam int LIMIT_MARGIN = 50;
	localparam int REF_STEP_CAP = 1000;
	localparam int SEED         = 32'h1b0d;
	localparam int IMEM_SIZE    = 1 << IADDR_W;
	localparam int DMEM_SIZE    = 1 << DADDR_W;
	localparam int NUM_PORTS    = 1 << IO_ADDR_W;

	// DUT ports
	logic     clk = 1'b0;
	logic     rst;
	instr_t   instr;
	iaddr_t   instr_addr;
	daddr_t   mem_addr_rd;
	word_t    mem_data_rd = '0;
	logic     mem_wr;
	daddr_t   mem_addr_wr;
	word_t    mem_data_wr;
	logic     req_in;
	io_addr_t addr_in;
	word_t    io_in;
	logic     out_en;
	io_addr_t addr_out;
	word_t    io_out;

	// Models --------------------
	instr_t imem [IMEM_SIZE];
	word_t  dmem [DMEM_SIZE];
	word_t  mem_init [DMEM_SIZE];
	word_t  io_table [NUM_PORTS];
	int     load_ptr;
	integer seed;

	// Expected events of all programs in run order
	daddr_t   exp_wr_addr [$];
	word_t    exp_wr_data [$];
	io_addr_t exp_out_addr [$];
	word_t    exp_out_data [$];
	int       wr_end [NUM_PROGS];
	int       out_end [NUM_PROGS];

	int wr_idx         = 0;
	int out_idx        = 0;
	int ends_seen      = 0;
	int write_errors   = 0;
	int out_errors     = 0;
	int extra_errors   = 0;
	int missing_errors = 0;
	int cycles         = 0;
	int cycle_limit    = 0;
	int total_steps;

	`include "tb_ref_model.svh"

	always #50 clk = ~clk;

	stack_cpu uut (.*);

	// Combinational instruction fetch
	assign instr = imem[instr_addr];
	// Port data only while a read is requested
	assign io_in = req_in ? io_table[addr_in] : '0;

	// Write-first data memory
	// Image reloaded while reset is held
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DMEM_SIZE; i++) begin
				dmem[i] <= mem_init[i];
			end
		end else begin
			if (mem_wr) begin
				dmem[mem_addr_wr] <= mem_data_wr;
			end
			if (mem_wr && mem_addr_wr == mem_addr_rd) begin
				mem_data_rd <= mem_data_wr;
			end else begin
				mem_data_rd <= dmem[mem_addr_rd];
			end
		end
	end

	// Compare --------------------
	task automatic check_write(input daddr_t addr, input word_t data,
			input daddr_t exp_addr, input word_t exp_data);
		if (addr != exp_addr || data != exp_data) begin
			$display("MISMATCH mem_addr_wr/mem_data_wr: got %h/%h expected %h/%h",
				addr, data, exp_addr, exp_data);
			write_errors++;
		end
	endtask

	task automatic check_out(input io_addr_t addr, input word_t data,
			input io_addr_t exp_addr, input word_t exp_data);
		if (addr != exp_addr || data != exp_data) begin
			$display("MISMATCH addr_out/io_out: got %h/%h expected %h/%h",
				addr, data, exp_addr, exp_data);
			out_errors++;
		end
	endtask

	// Strobes are settled at the falling edge
	always @(negedge clk) begin
		if (!rst && mem_wr) begin
			if (wr_idx < exp_wr_addr.size()) begin
				check_write(mem_addr_wr, mem_data_wr,
					exp_wr_addr[wr_idx], exp_wr_data[wr_idx]);
			end else begin
				$display("Unexpected memory write to address %h", mem_addr_wr);
				extra_errors++;
			end
			wr_idx++;
		end
		if (!rst && out_en) begin
			if (out_idx < exp_out_addr.size()) begin
				check_out(addr_out, io_out,
					exp_out_addr[out_idx], exp_out_data[out_idx]);
			end else begin
				$display("Unexpected port output on port %h", addr_out);
				extra_errors++;
			end
			out_idx++;
			if (addr_out == 3'd7) begin
				ends_seen++;
			end
		end
	end

	// Cycle watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Hang: program %0d did not finish within %0d cycles",
				ends_seen, cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// Sequencing --------------------
	initial begin
		rst         = 1'b1;
		seed        = SEED;
		total_steps = 0;
		for (int i = 0; i < DMEM_SIZE; i++) begin
			mem_init[i] = word_t'($random(seed));
		end
		for (int i = 0; i < NUM_PORTS; i++) begin
			io_table[i] = word_t'($random(seed));
		end
		// Minus one and loop count
		mem_init[9'h1f0] = 16'hffff;
		mem_init[9'h1f1] = 16'd4;

		for (int p = 0; p < NUM_PROGS; p++) begin
			load_program(p);
			total_steps += stack_cpu_ref();
			wr_end[p]  = exp_wr_addr.size();
			out_end[p] = exp_out_addr.size();
		end
		cycle_limit = total_steps * 2 + LIMIT_MARGIN * NUM_PROGS;

		for (int p = 0; p < NUM_PROGS; p++) begin
			@(posedge clk);
			rst <= 1'b1;
			@(posedge clk);
			load_program(p);
			repeat (4) @(posedge clk);
			rst <= 1'b0;
			wait (ends_seen > p);
			// Let the last strobes drain before counting
			repeat (3) @(posedge clk);
			if (wr_idx != wr_end[p] || out_idx != out_end[p]) begin
				$display("Program %0d: %0d of %0d writes and %0d of %0d outputs seen",
					p, wr_idx, wr_end[p], out_idx, out_end[p]);
				missing_errors++;
			end
		end

		$display("Errors: write %0d, output %0d, extra %0d, missing %0d",
			write_errors, out_errors, extra_errors, missing_errors);
		if (write_errors + out_errors + extra_errors + missing_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- stack_cpu.f
+incdir+include
rtl/stack_cpu_pkg.sv
rtl/lifo_stack.sv
rtl/instr_fetch.sv
rtl/exec_unit.sv
rtl/io_mem_ctrl.sv
rtl/stack_cpu.sv
sim/tb_stack_cpu.sv
